// File: fadd_top.f
hw/fadd_pkg.sv
hw/fadd_special.sv
hw/fadd_align.sv
hw/fadd_round_ctrl.sv
hw/fadd_norm_round.sv
hw/fadd_top.sv
dv/fadd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fadd testbench with verilator, run it, and grep the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module fadd_tb -f fadd_top.f \
  -o fadd_sim > build.log 2>&1 \
  && ./obj_dir/fadd_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/fadd_tb.sv
// ##############################
// fadd testbench
// random and directed float add/sub, special operands,
// copy and logic ops, checked against a reference model
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_tb;

  logic                          clk, rst, sub, en, copy_a, logic_en;
  logic [fadd_pkg::WORD_W-1:0]   a, b;
  logic [2:0]                    rmode;
  logic [1:0]                    logic_sel;
  wire  [fadd_pkg::WORD_W-1:0]   res;
  wire                           res_valid;

  logic [fadd_pkg::WORD_W-1:0]   exp_q[$];
  string                         name_q[$];
  logic [fadd_pkg::WORD_W-1:0]   expv;
  logic [fadd_pkg::WORD_W-1:0]   last_exp;
  string                         nm;
  logic                          en_q1, en_q2;
  int                            checks, errors, timeouts, rnd_seed;

  fadd_top u_dut (
    .clk(clk), .rst(rst), .a(a), .b(b), .sub(sub), .rmode(rmode), .en(en),
    .copy_a(copy_a), .logic_en(logic_en), .logic_sel(logic_sel),
    .res(res), .res_valid(res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [fadd_pkg::WORD_W-1:0] make_word(input logic s,
      input logic [8:0] e, input logic [22:0] f);
    fadd_pkg::fp_word_u w;
    w.fp.exp_hi = e[8];
    w.fp.sign   = s;
    w.fp.exp_lo = e[7:0];
    w.fp.frac   = f;
    return w.raw;
  endfunction

  function automatic logic [fadd_pkg::WORD_W-1:0] rand_normal(input int e);
    int ec;
    ec = (e < 1) ? 1 : ((e > int'(fadd_pkg::EXP_MAX)) ? int'(fadd_pkg::EXP_MAX) : e);
    return make_word(1'($urandom_range(0, 1)), 9'(ec), 23'($urandom));
  endfunction

  // expected word from the format rules, exact sum then explicit rounding
  function automatic logic [fadd_pkg::WORD_W-1:0] ref_result(
      input logic [fadd_pkg::WORD_W-1:0] op_a, input logic [fadd_pkg::WORD_W-1:0] op_b,
      input logic op_sub, input logic [2:0] mode, input logic cp, input logic lg,
      input logic [1:0] sel);
    fadd_pkg::fp_word_u ua, ub;
    int ea, eb, e_big, d, p, k, e_res;
    logic sa, sb, s_big, a_big, up;
    longint unsigned ma, mb, x_big, x_small, x, m, r, half;
    ua.raw = op_a;
    ub.raw = op_b;
    if (cp) return op_a;
    if (lg) begin
      case (sel)
        fadd_pkg::LOGIC_AND: return op_a & op_b;
        fadd_pkg::LOGIC_OR:  return op_a | op_b;
        fadd_pkg::LOGIC_XOR: return op_a ^ op_b;
        default:             return op_a & ~op_b;
      endcase
    end
    ea = int'({ua.fp.exp_hi, ua.fp.exp_lo});
    eb = int'({ub.fp.exp_hi, ub.fp.exp_lo});
    sa = ua.fp.sign;
    sb = ub.fp.sign ^ op_sub;
    if (ea == int'(fadd_pkg::EXP_NAN) || eb == int'(fadd_pkg::EXP_NAN)) return fadd_pkg::NAN_WORD;
    if (ea == int'(fadd_pkg::EXP_INF) && eb == int'(fadd_pkg::EXP_INF) && sa != sb)
      return fadd_pkg::NAN_WORD;
    if (ea == int'(fadd_pkg::EXP_INF)) return make_word(sa, fadd_pkg::EXP_INF, 23'd0);
    if (eb == int'(fadd_pkg::EXP_INF)) return make_word(sb, fadd_pkg::EXP_INF, 23'd0);
    if (ea == 0 && eb == 0) return (sa == sb) ? op_a : '0;
    if (eb == 0) return op_a;
    if (ea == 0) return make_word(sb, 9'(eb), ub.fp.frac);
    ma = 64'(ua.fp.frac) | (64'd1 << 23);
    mb = 64'(ub.fp.frac) | (64'd1 << 23);
    a_big = (ea > eb) || (ea == eb && ma >= mb);
    e_big = a_big ? ea : eb;
    s_big = a_big ? sa : sb;
    d = a_big ? ea - eb : eb - ea;
    x_big = (a_big ? ma : mb) << 30;
    if (d <= 30) x_small = (a_big ? mb : ma) << (30 - d);
    // far below the guard bit, only its presence matters
    else x_small = 64'd1;
    x = (sa != sb) ? x_big - x_small : x_big + x_small;
    if (x == 64'd0) return '0;
    p = 63;
    while (p > 0 && !x[p]) p--;
    k = p - 23;
    m = x >> k;
    r = x - (m << k);
    half = 64'd1 << (k - 1);
    e_res = e_big + p - 53;
    up = 1'b0;
    if (mode == fadd_pkg::RND_EVEN) up = (r > half) || (r == half && m[0]);
    else if (mode == fadd_pkg::RND_UP) up = !s_big && r != 64'd0;
    else if (mode == fadd_pkg::RND_DOWN) up = s_big && r != 64'd0;
    if (up) begin
      m = m + 64'd1;
      if (m == (64'd1 << 24)) begin
        m = 64'd1 << 23;
        e_res = e_res + 1;
      end
    end
    if (e_res > int'(fadd_pkg::EXP_MAX)) return make_word(s_big, fadd_pkg::EXP_INF, 23'd0);
    if (e_res < 1) return '0;
    return make_word(s_big, 9'(e_res), m[22:0]);
  endfunction

  task automatic drive_op(input string name, input logic [fadd_pkg::WORD_W-1:0] op_a,
      input logic [fadd_pkg::WORD_W-1:0] op_b, input logic op_sub, input logic [2:0] mode,
      input logic cp, input logic lg, input logic [1:0] sel);
    @(posedge clk);
    #5;
    a = op_a;
    b = op_b;
    sub = op_sub;
    rmode = mode;
    copy_a = cp;
    logic_en = lg;
    logic_sel = sel;
    en = 1'b1;
    exp_q.push_back(ref_result(op_a, op_b, op_sub, mode, cp, lg, sel));
    name_q.push_back(name);
  endtask

  task automatic add_sub(input string name, input logic [fadd_pkg::WORD_W-1:0] op_a,
      input logic [fadd_pkg::WORD_W-1:0] op_b, input logic op_sub, input logic [2:0] mode);
    drive_op(name, op_a, op_b, op_sub, mode, 1'b0, 1'b0, 2'd0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #5;
      en = 1'b0;
      copy_a = 1'b0;
      logic_en = 1'b0;
    end
  endtask

  // en seen two edges back lines up with res_valid
  always @(posedge clk) begin
    en_q1 <= en;
    en_q2 <= en_q1;
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (res_valid !== en_q2) begin
        errors++;
        $display("[FAIL] res_valid_timing: expected %b, actual %b", en_q2, res_valid);
      end
      if (res_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("res_valid came with no operation pending");
        end else begin
          expv = exp_q.pop_front();
          nm = name_q.pop_front();
          last_exp = expv;
          checks++;
          if (res !== expv) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", nm, expv, res);
          end
        end
      end else if (res !== last_exp) begin
        // result stays put between pulses
        errors++;
        $display("[FAIL] res_hold: expected %h, actual %h", last_exp, res);
      end
    end
  end

  initial begin
    int e0, waited;
    logic [fadd_pkg::WORD_W-1:0] op_a, op_b, max_w;
    logic op_sub;
    rnd_seed = $urandom(15503);
    rst = 1'b1;
    {a, b, sub, rmode, en, copy_a, logic_en, logic_sel} = '0;
    {en_q1, en_q2} = 2'b00;
    last_exp = '0;
    {checks, errors, timeouts} = '0;
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;
    idle_cycles(4);

    add_sub("nan_a", make_word(1'b0, fadd_pkg::EXP_NAN, 23'h1234), rand_normal(100), 1'b0,
            fadd_pkg::RND_EVEN);
    add_sub("nan_b", rand_normal(90), make_word(1'b1, fadd_pkg::EXP_NAN, 23'h0), 1'b1,
            fadd_pkg::RND_TRUNC);
    add_sub("inf_minus_inf", make_word(1'b0, fadd_pkg::EXP_INF, 23'd0),
            make_word(1'b0, fadd_pkg::EXP_INF, 23'd0), 1'b1, fadd_pkg::RND_EVEN);
    add_sub("inf_plus_fin", make_word(1'b1, fadd_pkg::EXP_INF, 23'd0), rand_normal(300),
            1'b0, fadd_pkg::RND_UP);
    add_sub("fin_minus_inf", rand_normal(20), make_word(1'b0, fadd_pkg::EXP_INF, 23'd0),
            1'b1, fadd_pkg::RND_DOWN);
    add_sub("zero_opp", make_word(1'b0, 9'd0, 23'h55), make_word(1'b1, 9'd0, 23'd0), 1'b0,
            fadd_pkg::RND_DOWN);
    add_sub("zero_same", make_word(1'b1, 9'd0, 23'd0), make_word(1'b0, 9'd0, 23'd7), 1'b1,
            fadd_pkg::RND_EVEN);
    add_sub("b_zero", rand_normal(200), make_word(1'b1, 9'd0, 23'd3), 1'b0, fadd_pkg::RND_UP);
    add_sub("a_zero_sub", make_word(1'b0, 9'd0, 23'd0), rand_normal(150), 1'b1,
            fadd_pkg::RND_TRUNC);
    drive_op("copy_a", make_word(1'b1, fadd_pkg::EXP_NAN, 23'h2aaaaa), rand_normal(10),
             1'b1, 3'd0, 1'b1, 1'b0, 2'd2);
    for (int s = 0; s < 4; s++) begin
      drive_op($sformatf("logic_sel_%0d", s), {1'($urandom), $urandom},
               {1'($urandom), $urandom}, 1'b0, 3'd0, 1'b0, 1'b1, 2'(s));
    end
    idle_cycles(2);

    max_w = make_word(1'b0, fadd_pkg::EXP_MAX, 23'h7fffff);
    add_sub("overflow_add", max_w, max_w, 1'b0, fadd_pkg::RND_TRUNC);
    add_sub("overflow_round", max_w, make_word(1'b0, 9'h1d0, 23'd0), 1'b0, fadd_pkg::RND_UP);
    add_sub("underflow", make_word(1'b0, 9'd1, 23'd1), make_word(1'b0, 9'd1, 23'd0), 1'b1,
            fadd_pkg::RND_EVEN);
    op_a = rand_normal(250);
    add_sub("cancel_sub", op_a, op_a, 1'b1, fadd_pkg::RND_DOWN);
    add_sub("cancel_add", op_a, {op_a[32], ~op_a[31], op_a[30:0]}, 1'b0, fadd_pkg::RND_UP);
    idle_cycles(1);

    for (int i = 0; i < 300; i++) begin
      e0 = int'($urandom_range(40, 'h1c0));
      op_sub = 1'($urandom_range(0, 1));
      case (i % 5)
        0: begin
          op_a = rand_normal(e0);
          op_b = rand_normal(e0 + int'($urandom_range(0, 80)) - 40);
        end
        1: begin
          op_a = rand_normal(e0);
          op_b = op_a ^ {10'd0, 23'($urandom_range(1, 255))};
          op_sub = 1'b1;
        end
        // one exponent apart, nearly equal
        2: begin
          op_a = make_word(1'b0, 9'(e0), 23'h7fffff ^ 23'($urandom_range(0, 63)));
          op_b = make_word(1'b0, 9'(e0 + 1), 23'($urandom_range(0, 63)));
          op_sub = 1'b1;
        end
        3: begin
          op_a = rand_normal(int'(fadd_pkg::EXP_MAX) - int'($urandom_range(0, 3)));
          op_b = rand_normal(int'(fadd_pkg::EXP_MAX) - int'($urandom_range(0, 30)));
        end
        default: begin
          op_a = rand_normal(int'($urandom_range(1, 6)));
          op_b = rand_normal(int'($urandom_range(1, 30)));
        end
      endcase
      add_sub($sformatf("rand_%0d", i), op_a, op_b, op_sub, 3'($urandom_range(0, 7)));
      if ($urandom_range(0, 3) == 0) idle_cycles(1);
    end
    idle_cycles(1);

    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("timeout: %0d results never arrived", exp_q.size());
    end
    idle_cycles(2);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/fadd_top.sv
// ##############################
// fadd top level
// two-stage float add/sub with special cases and logic ops
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_top (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [fadd_pkg::WORD_W-1:0]   a,
  input  wire  [fadd_pkg::WORD_W-1:0]   b,
  input  wire                           sub,
  input  wire  [2:0]                    rmode,
  input  wire                           en,
  input  wire                           copy_a,
  input  wire                           logic_en,
  input  wire  [1:0]                    logic_sel,
  output logic [fadd_pkg::WORD_W-1:0]   res,
  output logic                          res_valid
);

  logic                          spec_hit;
  logic [fadd_pkg::WORD_W-1:0]   spec_res;
  logic                          next_sign, big_sign, eff_sub, small_sticky;
  logic [fadd_pkg::EXP_W-1:0]    big_exp;
  logic [fadd_pkg::MANT_W-1:0]   big_mant;
  logic [fadd_pkg::EXT_W-1:0]    small_ext;
  logic                          s1_valid, rnd_zero, rnd_even, rnd_inc;

  fadd_special u_special (
    .clk(clk), .rst(rst), .a(a), .b(b), .sub(sub),
    .copy_a(copy_a), .logic_en(logic_en), .logic_sel(logic_sel),
    .spec_hit(spec_hit), .spec_res(spec_res)
  );

  fadd_align u_align (
    .clk(clk), .rst(rst), .a(a), .b(b), .sub(sub),
    .next_sign(next_sign), .big_sign(big_sign), .big_exp(big_exp),
    .big_mant(big_mant), .small_ext(small_ext), .small_sticky(small_sticky),
    .eff_sub(eff_sub)
  );

  fadd_round_ctrl u_round_ctrl (
    .clk(clk), .rst(rst), .en(en), .rmode(rmode), .next_sign(next_sign),
    .s1_valid(s1_valid), .rnd_zero(rnd_zero), .rnd_even(rnd_even), .rnd_inc(rnd_inc)
  );

  fadd_norm_round u_norm_round (
    .clk(clk), .rst(rst), .s1_valid(s1_valid),
    .spec_hit(spec_hit), .spec_res(spec_res),
    .big_sign(big_sign), .big_exp(big_exp), .big_mant(big_mant),
    .small_ext(small_ext), .small_sticky(small_sticky), .eff_sub(eff_sub),
    .rnd_zero(rnd_zero), .rnd_even(rnd_even), .rnd_inc(rnd_inc),
    .res(res), .res_valid(res_valid)
  );

endmodule

`default_nettype wire

// File: hw/fadd_norm_round.sv
// ##############################
// fadd normalize and round stage
// mantissa add/sub, normalize, round, range clamp,
// final result register
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_norm_round (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           s1_valid,
  input  wire                           spec_hit,
  input  wire  [fadd_pkg::WORD_W-1:0]   spec_res,
  input  wire                           big_sign,
  input  wire  [fadd_pkg::EXP_W-1:0]    big_exp,
  input  wire  [fadd_pkg::MANT_W-1:0]   big_mant,
  input  wire  [fadd_pkg::EXT_W-1:0]    small_ext,
  input  wire                           small_sticky,
  input  wire                           eff_sub,
  input  wire                           rnd_zero,
  input  wire                           rnd_even,
  input  wire                           rnd_inc,
  output logic [fadd_pkg::WORD_W-1:0]   res,
  output logic                          res_valid
);

  // carry, hidden, fraction, guard, round, sticky
  logic [fadd_pkg::EXT_W+1:0]    big_x, small_x, sum, norm;
  logic [4:0]                    lz;
  logic [fadd_pkg::MANT_W-1:0]   mant;
  logic                          guard, sticky, round_up, rnd_carry;
  logic [fadd_pkg::MANT_W:0]     rm;
  logic [fadd_pkg::FRAC_W-1:0]   frac;
  logic signed [10:0]            e_norm, e_fin;
  logic [fadd_pkg::WORD_W-1:0]   arith;

  assign big_x   = {1'b0, big_mant, 3'b000};
  assign small_x = {1'b0, small_ext, small_sticky};

  // big is never smaller in magnitude, so a subtract stays non-negative
  assign sum = eff_sub ? big_x - small_x : big_x + small_x;

  // leading zero count, 28 when the sum is zero
  always_comb begin
    lz = 5'(fadd_pkg::EXT_W + 2);
    for (int i = 0; i < fadd_pkg::EXT_W + 2; i++) begin
      if (sum[i]) begin
        lz = 5'(fadd_pkg::EXT_W + 1 - i);
      end
    end
  end

  // leading one lands in the top bit, carry-out case included
  assign norm   = sum << lz;
  assign mant   = norm[fadd_pkg::EXT_W+1:4];
  assign guard  = norm[3];
  assign sticky = |norm[2:0];
  assign e_norm = {2'b00, big_exp} + 11'd1 - {6'b000000, lz};

  assign round_up = ~rnd_zero & ((rnd_inc & (guard | sticky)) |
                                 (rnd_even & guard & (sticky | mant[0])));

  assign rm        = {1'b0, mant} + {{fadd_pkg::MANT_W{1'b0}}, round_up};
  assign rnd_carry = rm[fadd_pkg::MANT_W];
  // an all-ones mantissa rounds to 1.0 at the next exponent
  assign frac  = rnd_carry ? rm[fadd_pkg::MANT_W-1:1] : rm[fadd_pkg::FRAC_W-1:0];
  assign e_fin = e_norm + {10'd0, rnd_carry};

  always_comb begin
    if (sum == '0) begin
      arith = '0;
    end else if (e_fin > $signed({2'b00, fadd_pkg::EXP_MAX})) begin
      arith = {fadd_pkg::EXP_INF[8], big_sign, fadd_pkg::EXP_INF[7:0],
               {fadd_pkg::FRAC_W{1'b0}}};
    end else if (e_fin < 11'sd1) begin
      arith = '0;
    end else begin
      arith = {e_fin[8], big_sign, e_fin[7:0], frac};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
      if (s1_valid) begin
        res <= spec_hit ? spec_res : arith;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fadd_round_ctrl.sv
// ##############################
// fadd rounding control
// mode and result sign into registered round controls,
// also holds the stage-1 valid bit
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_round_ctrl (
  input  wire        clk,
  input  wire        rst,
  input  wire        en,
  input  wire  [2:0] rmode,
  input  wire        next_sign,
  output logic       s1_valid,
  output logic       rnd_zero,
  output logic       rnd_even,
  output logic       rnd_inc
);

  logic zero_c, even_c, inc_c;

  always_comb begin
    zero_c = 1'b0;
    even_c = 1'b0;
    inc_c  = 1'b0;
    case (rmode)
      fadd_pkg::RND_TRUNC: zero_c = 1'b1;
      fadd_pkg::RND_EVEN:  even_c = 1'b1;
      // toward +inf, magnitude grows only when positive
      fadd_pkg::RND_UP: begin
        inc_c  = ~next_sign;
        zero_c = next_sign;
      end
      fadd_pkg::RND_DOWN: begin
        inc_c  = next_sign;
        zero_c = ~next_sign;
      end
      default: zero_c = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      rnd_zero <= 1'b1;
      rnd_even <= 1'b0;
      rnd_inc  <= 1'b0;
    end else begin
      s1_valid <= en;
      rnd_zero <= zero_c;
      rnd_even <= even_c;
      rnd_inc  <= inc_c;
    end
  end

endmodule

`default_nettype wire

// File: hw/fadd_align.sv
// ##############################
// fadd alignment stage
// swaps operands by magnitude and shifts the smaller
// mantissa right with guard, round and sticky
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_align (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [fadd_pkg::WORD_W-1:0]   a,
  input  wire  [fadd_pkg::WORD_W-1:0]   b,
  input  wire                           sub,
  output logic                          next_sign,
  output logic                          big_sign,
  output logic [fadd_pkg::EXP_W-1:0]    big_exp,
  output logic [fadd_pkg::MANT_W-1:0]   big_mant,
  output logic [fadd_pkg::EXT_W-1:0]    small_ext,
  output logic                          small_sticky,
  output logic                          eff_sub
);

  fadd_pkg::fp_word_u             ua;
  fadd_pkg::fp_word_u             ub;
  logic [fadd_pkg::EXP_W-1:0]     a_exp, b_exp;
  logic [fadd_pkg::EXP_W-1:0]     big_e, small_e, diff;
  logic [fadd_pkg::MANT_W-1:0]    a_mant, b_mant, big_m, small_m;
  logic                           a_s, b_s, a_big;
  logic [4:0]                     sh;
  logic [2*fadd_pkg::EXT_W-1:0]   wide;

  assign ua.raw = a;
  assign ub.raw = b;
  assign a_exp  = {ua.fp.exp_hi, ua.fp.exp_lo};
  assign b_exp  = {ub.fp.exp_hi, ub.fp.exp_lo};
  assign a_mant = {1'b1, ua.fp.frac};
  assign b_mant = {1'b1, ub.fp.frac};
  assign a_s    = ua.fp.sign;
  assign b_s    = ub.fp.sign ^ sub;

  // exponent then fraction, ties keep a as the big operand
  assign a_big = {a_exp, ua.fp.frac} >= {b_exp, ub.fp.frac};

  assign big_e   = a_big ? a_exp : b_exp;
  assign small_e = a_big ? b_exp : a_exp;
  assign big_m   = a_big ? a_mant : b_mant;
  assign small_m = a_big ? b_mant : a_mant;
  assign diff    = big_e - small_e;

  // saturate, a shift of EXT_W already pushes everything into sticky
  assign sh = (diff > 9'(fadd_pkg::EXT_W)) ? 5'(fadd_pkg::EXT_W) : diff[4:0];

  assign wide = {small_m, {(fadd_pkg::EXT_W-fadd_pkg::MANT_W){1'b0}},
                 {fadd_pkg::EXT_W{1'b0}}} >> sh;

  assign next_sign = a_big ? a_s : b_s;

  always_ff @(posedge clk) begin
    if (rst) begin
      big_sign <= 1'b0;
      eff_sub  <= 1'b0;
    end else begin
      big_sign <= next_sign;
      eff_sub  <= a_s ^ b_s;
    end
  end

  always_ff @(posedge clk) begin
    big_exp      <= big_e;
    big_mant     <= big_m;
    small_ext    <= wide[2*fadd_pkg::EXT_W-1:fadd_pkg::EXT_W];
    small_sticky <= |wide[fadd_pkg::EXT_W-1:0];
  end

endmodule

`default_nettype wire

// File: hw/fadd_special.sv
// ##############################
// fadd special-case stage
// copy, bitwise ops and nan / inf / zero operands,
// registered hit flag and result word
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fadd_special (
  input  wire                            clk,
  input  wire                            rst,
  input  wire  [fadd_pkg::WORD_W-1:0]    a,
  input  wire  [fadd_pkg::WORD_W-1:0]    b,
  input  wire                            sub,
  input  wire                            copy_a,
  input  wire                            logic_en,
  input  wire  [1:0]                     logic_sel,
  output logic                           spec_hit,
  output logic [fadd_pkg::WORD_W-1:0]    spec_res
);

  fadd_pkg::fp_word_u           ua;
  fadd_pkg::fp_word_u           ub;
  logic [fadd_pkg::EXP_W-1:0]   a_exp;
  logic [fadd_pkg::EXP_W-1:0]   b_exp;
  logic                         a_s, b_s;
  logic                         a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
  logic                         hit;
  logic [fadd_pkg::WORD_W-1:0]  word;

  assign ua.raw = a;
  assign ub.raw = b;
  assign a_exp  = {ua.fp.exp_hi, ua.fp.exp_lo};
  assign b_exp  = {ub.fp.exp_hi, ub.fp.exp_lo};

  // effective signs, sub flips b
  assign a_s = ua.fp.sign;
  assign b_s = ub.fp.sign ^ sub;

  assign a_nan  = a_exp == fadd_pkg::EXP_NAN;
  assign b_nan  = b_exp == fadd_pkg::EXP_NAN;
  assign a_inf  = a_exp == fadd_pkg::EXP_INF;
  assign b_inf  = b_exp == fadd_pkg::EXP_INF;
  assign a_zero = a_exp == '0;
  assign b_zero = b_exp == '0;

  // first matching rule wins
  always_comb begin
    hit  = 1'b1;
    word = a;
    if (copy_a) begin
      word = a;
    end else if (logic_en) begin
      case (logic_sel)
        fadd_pkg::LOGIC_AND:  word = ua.raw & ub.raw;
        fadd_pkg::LOGIC_OR:   word = ua.raw | ub.raw;
        fadd_pkg::LOGIC_XOR:  word = ua.raw ^ ub.raw;
        fadd_pkg::LOGIC_ANDN: word = ua.raw & ~ub.raw;
        default:              word = ua.raw & ub.raw;
      endcase
    end else if (a_nan || b_nan || (a_inf && b_inf && (a_s != b_s))) begin
      word = fadd_pkg::NAN_WORD;
    end else if (a_inf || b_inf) begin
      word = {fadd_pkg::EXP_INF[8], a_inf ? a_s : b_s, fadd_pkg::EXP_INF[7:0],
              {fadd_pkg::FRAC_W{1'b0}}};
    end else if (a_zero && b_zero) begin
      // opposite zeros cancel to +0
      word = (a_s == b_s) ? a : '0;
    end else if (b_zero) begin
      word = a;
    end else if (a_zero) begin
      word = {ub.fp.exp_hi, b_s, ub.fp.exp_lo, ub.fp.frac};
    end else begin
      hit = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spec_hit <= 1'b0;
    end else begin
      spec_hit <= hit;
    end
  end

  always_ff @(posedge clk) begin
    spec_res <= word;
  end

endmodule

`default_nettype wire

// File: hw/fadd_pkg.sv
// ##############################
// fadd package
// internal 33-bit float word format, rounding and logic codes,
// special-value constants and the two-way operand view
// ##############################
`default_nettype none

package fadd_pkg;

  // word geometry
  localparam int WORD_W = 33;
  localparam int EXP_W  = 9;
  localparam int FRAC_W = 23;
  localparam int MANT_W = 24;
  // mantissa plus guard and round, sticky kept apart
  localparam int EXT_W  = 26;

  // exponent codes, 0 is zero and there are no denormals
  localparam logic [EXP_W-1:0] EXP_INF = 9'h1fe;
  localparam logic [EXP_W-1:0] EXP_NAN = 9'h1ff;
  localparam logic [EXP_W-1:0] EXP_MAX = 9'h1fd;

  // canonical nan, sign set, top and bottom fraction bits set
  localparam logic [WORD_W-1:0] NAN_WORD = {1'b1, 1'b1, 8'hff, 23'h400001};

  // rounding modes, unlisted codes truncate
  localparam logic [2:0] RND_TRUNC = 3'd0;
  localparam logic [2:0] RND_EVEN  = 3'd2;
  localparam logic [2:0] RND_UP    = 3'd5;
  localparam logic [2:0] RND_DOWN  = 3'd6;

  // bitwise op select
  localparam logic [1:0] LOGIC_AND  = 2'd0;
  localparam logic [1:0] LOGIC_OR   = 2'd1;
  localparam logic [1:0] LOGIC_XOR  = 2'd2;
  localparam logic [1:0] LOGIC_ANDN = 2'd3;

  // float fields for the arithmetic, raw bits for logic ops and copy
  typedef union packed {
    struct packed {
      logic              exp_hi;
      logic              sign;
      logic [7:0]        exp_lo;
      logic [FRAC_W-1:0] frac;
    } fp;
    logic [WORD_W-1:0] raw;
  } fp_word_u;

endpackage

`default_nettype wire
